// ==== hw/histPkg.sv ====
`default_nettype none

package histPkg;

    // bins run 1..numBins, address 0 means no bin
    localparam int numBins = 8;

    // one spare bit above log2(numBins) keeps 0 free as "no bin"
    localparam int binAddrWidth = 4;

    // coarse counters saturate at 63
    localparam int coarseCountWidth = 6;

    // fine counters saturate at 255
    localparam int fineCountWidth = 8;

    // one scan cycle per bin
    localparam int scanLength = numBins;

    // bin address
    typedef logic [binAddrWidth-1:0] binAddr_t;

    // count payloads of the two histograms
    typedef logic [coarseCountWidth-1:0] coarseCount_t;
    typedef logic [fineCountWidth-1:0] fineCount_t;

endpackage

`default_nettype wire

// ==== hw/histBusIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface histBusIf import histPkg::*; ();

    // increment strobes, one per histogram
    logic chInc;
    logic fhInc;
    // bin to increment
    binAddr_t hitBin;

    // high for the whole post-acquisition scan
    logic scan;
    // bin being read and cleared
    binAddr_t scanBin;
    // final scan step
    logic scanLast;

    // sequencer drives everything
    modport seq(output chInc, fhInc, hitBin, scan, scanBin, scanLast);

    // banks get their strobe on a separate port
    modport bank(input hitBin, scan, scanBin);

    // peak detector only follows the scan
    modport peak(input scan, scanBin, scanLast);

endinterface

`default_nettype wire

// ==== hw/hitSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module hitSequencer import histPkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic [1:0] wrEn,
    input  wire binAddr_t addr,
    input  wire logic     acqFinish,
    histBusIf.seq         bus
);

    // input stage
    logic [1:0] wrEnQ;
    binAddr_t   addrQ;
    logic       acqQ;

    // qualification of the registered hit
    logic addrLegal;
    logic scanNext;

    // bin 0 and anything above numBins never reach the banks
    assign addrLegal = (addrQ != '0) && (addrQ <= binAddr_t'(numBins));

    // scan state after the coming edge
    // idle: starts on a pending acqFinish, running: ends after scanLast
    assign scanNext = bus.scan ? !bus.scanLast : acqQ;

    // sample the hit, drop it right away if a scan is running
    always_ff @(posedge clk) begin
        if (reset) begin
            wrEnQ <= 2'b00;
            acqQ  <= 1'b0;
        end else begin
            wrEnQ <= bus.scan ? 2'b00 : wrEn;
            acqQ  <= acqFinish;
        end
    end

    // address is payload, qualified by wrEnQ
    always_ff @(posedge clk) begin
        addrQ <= addr;
    end

    // forward legal hits
    // also held back on the edge that starts a scan
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.chInc <= 1'b0;
            bus.fhInc <= 1'b0;
        end else begin
            bus.chInc <= wrEnQ[0] && addrLegal && !scanNext;
            bus.fhInc <= wrEnQ[1] && addrLegal && !scanNext;
        end
    end

    always_ff @(posedge clk) begin
        bus.hitBin <= addrQ;
    end

    // scan counter, steps scanBin through 1..numBins
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.scan     <= 1'b0;
            bus.scanBin  <= '0;
            bus.scanLast <= 1'b0;
        end else if (!bus.scan) begin
            // acqFinish while running is simply not looked at
            if (acqQ) begin
                bus.scan     <= 1'b1;
                bus.scanBin  <= binAddr_t'(1);
                bus.scanLast <= (scanLength == 1);
            end
        end else if (bus.scanLast) begin
            bus.scan     <= 1'b0;
            bus.scanBin  <= '0;
            bus.scanLast <= 1'b0;
        end else begin
            bus.scanBin  <= binAddr_t'(bus.scanBin + 1'b1);
            // next step is the last one
            bus.scanLast <= (bus.scanBin == binAddr_t'(scanLength - 1));
        end
    end

    // banks must never see an increment while they are being cleared
    assert property (@(posedge clk) disable iff (reset)
        bus.scan |-> !(bus.chInc || bus.fhInc));

    // scan address never leaves the legal range
    assert property (@(posedge clk) disable iff (reset)
        bus.scan |-> (bus.scanBin >= binAddr_t'(1)) && (bus.scanBin <= binAddr_t'(numBins)));

endmodule

`default_nettype wire

// ==== hw/histogramBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module histogramBank import histPkg::*; #(
    parameter type countT = coarseCount_t
) (
    input  wire logic clk,
    input  wire logic reset,
    histBusIf.bank    bus,
    input  wire logic hitEn,
    output countT     readCount
);

    // saturation value, all ones of the payload
    localparam countT maxCount = '1;

    // one counter per bin, no bin 0
    countT cnt [1:numBins];

    // counter update
    // scan has priority, sequencer keeps hitEn low during it anyway
    always_ff @(posedge clk) begin
        if (reset) begin
            // reset mid-acquisition throws all counts away
            for (int i = 1; i <= numBins; i++) begin
                cnt[i] <= '0;
            end
        end else if (bus.scan) begin
            // read and clear in the same step
            cnt[bus.scanBin] <= '0;
        end else if (hitEn) begin
            // hold at max instead of wrapping
            if (cnt[bus.hitBin] != maxCount) begin
                cnt[bus.hitBin] <= countT'(cnt[bus.hitBin] + 1'b1);
            end
        end
    end

    // read port
    // data shows up one cycle after its scanBin
    always_ff @(posedge clk) begin
        if (bus.scan) begin
            readCount <= cnt[bus.scanBin];
        end
    end

    // a full counter only goes back to zero through a scan clear
    for (genvar i = 1; i <= numBins; i++) begin : gNoWrap
        assert property (@(posedge clk) disable iff (reset)
            (cnt[i] == maxCount) && !(bus.scan && (bus.scanBin == binAddr_t'(i)))
            |=> (cnt[i] != '0));
    end

endmodule

`default_nettype wire

// ==== hw/peakDetector.sv ====
`timescale 1ns/1ps
`default_nettype none

module peakDetector import histPkg::*; (
    input  wire logic         clk,
    input  wire logic         reset,
    histBusIf.peak            bus,
    input  wire coarseCount_t chCount,
    input  wire fineCount_t   fhCount,
    output binAddr_t          peakCh,
    output binAddr_t          peakFh,
    output logic              peakValid
);

    // scan control delayed to match the bank read latency
    logic     scanQ;
    binAddr_t scanBinQ;
    logic     scanLastQ;
    // last count has been folded into the trackers
    logic     doneQ;

    // running maximum and its bin, per histogram
    coarseCount_t chMax;
    binAddr_t     chBin;
    fineCount_t   fhMax;
    binAddr_t     fhBin;

    // alignment stage
    always_ff @(posedge clk) begin
        if (reset) begin
            scanQ     <= 1'b0;
            scanLastQ <= 1'b0;
            doneQ     <= 1'b0;
        end else begin
            scanQ     <= bus.scan;
            scanLastQ <= bus.scan && bus.scanLast;
            doneQ     <= scanLastQ;
        end
    end

    // bin number travels with the data
    always_ff @(posedge clk) begin
        scanBinQ <= bus.scanBin;
    end

    // trackers
    // strictly greater only, so ties keep the lower bin
    // max starts at 0, so an empty histogram leaves the bin at 0
    always_ff @(posedge clk) begin
        if (reset || doneQ) begin
            // also rearm for the next run once the peaks are out
            chMax <= '0;
            chBin <= '0;
            fhMax <= '0;
            fhBin <= '0;
        end else if (scanQ) begin
            if (chCount > chMax) begin
                chMax <= chCount;
                chBin <= scanBinQ;
            end
            if (fhCount > fhMax) begin
                fhMax <= fhCount;
                fhBin <= scanBinQ;
            end
        end
    end

    // result registers, peaks stay put until the next run
    always_ff @(posedge clk) begin
        if (reset) begin
            peakCh    <= '0;
            peakFh    <= '0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= doneQ;
            if (doneQ) begin
                peakCh <= chBin;
                peakFh <= fhBin;
            end
        end
    end

    // one pulse per scan
    assert property (@(posedge clk) disable iff (reset)
        peakValid |=> !peakValid);

endmodule

`default_nettype wire

// ==== hw/histogramTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module histogramTop import histPkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    // bit 0 coarse, bit 1 fine
    input  wire logic [1:0] wrEn,
    input  wire binAddr_t addr,
    input  wire logic     acqFinish,
    output binAddr_t      peakCh,
    output binAddr_t      peakFh,
    output logic          peakValid
);

    // shared hit and scan bus
    histBusIf histBus();

    // bank read data towards the peak detector
    coarseCount_t chCount;
    fineCount_t   fhCount;

    hitSequencer i_hitSequencer (
        .clk       (clk),
        .reset     (reset),
        .wrEn      (wrEn),
        .addr      (addr),
        .acqFinish (acqFinish),
        .bus       (histBus.seq)
    );

    // narrow saturating counters
    histogramBank #(
        .countT (coarseCount_t)
    ) coarseBank (
        .clk       (clk),
        .reset     (reset),
        .bus       (histBus.bank),
        .hitEn     (histBus.chInc),
        .readCount (chCount)
    );

    // wide saturating counters
    histogramBank #(
        .countT (fineCount_t)
    ) fineBank (
        .clk       (clk),
        .reset     (reset),
        .bus       (histBus.bank),
        .hitEn     (histBus.fhInc),
        .readCount (fhCount)
    );

    peakDetector i_peakDetector (
        .clk       (clk),
        .reset     (reset),
        .bus       (histBus.peak),
        .chCount   (chCount),
        .fhCount   (fhCount),
        .peakCh    (peakCh),
        .peakFh    (peakFh),
        .peakValid (peakValid)
    );

endmodule

`default_nettype wire

// ==== test/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int halfPeriod  = 20,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic reset
);

    // free-running clock, 40 ns period
    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // reset high over the first rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/histogramTopTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module histogramTopTb import histPkg::*; ();

    // saturation limits of the two histograms
    localparam int coarseMax   = (1 << coarseCountWidth) - 1;
    localparam int fineMax     = (1 << fineCountWidth) - 1;
    // generous bound on acqFinish to peakValid
    localparam int peakTimeout = 3 * numBins + 10;

    logic       clk;
    logic       powerOnReset;
    logic       resetPulse;
    logic       reset;
    logic [1:0] wrEn;
    binAddr_t   addr;
    logic       acqFinish;
    binAddr_t   peakCh;
    binAddr_t   peakFh;
    logic       peakValid;

    // reference model, one count per bin
    int chModel [1:numBins];
    int fhModel [1:numBins];
    // peaks expected from the current run
    binAddr_t expCh;
    binAddr_t expFh;

    string testName;
    int    errors;
    int    timeouts;
    int    validCount;
    int    seed;

    clockGen i_clockGen (
        .clk   (clk),
        .reset (powerOnReset)
    );

    // power-on reset plus pulses from the stimulus
    assign reset = powerOnReset | resetPulse;

    histogramTop i_histogramTop (
        .clk       (clk),
        .reset     (reset),
        .wrEn      (wrEn),
        .addr      (addr),
        .acqFinish (acqFinish),
        .peakCh    (peakCh),
        .peakFh    (peakFh),
        .peakValid (peakValid)
    );

    // peaks against the model on every result pulse
    assert property (@(posedge clk) disable iff (reset) peakValid |-> (peakCh == expCh))
        else begin
            errors++;
            $display("error %s expected %0d actual %0d", testName, expCh, peakCh);
        end

    assert property (@(posedge clk) disable iff (reset) peakValid |-> (peakFh == expFh))
        else begin
            errors++;
            $display("error %s expected %0d actual %0d", testName, expFh, peakFh);
        end

    // result pulses since the last acqFinish
    always @(negedge clk) begin
        if (!reset && peakValid) begin
            validCount++;
        end
    end

    // saturating count, legal bins only
    function automatic void modelHit(input logic [1:0] we, input binAddr_t a);
        if (a >= 1 && a <= numBins) begin
            if (we[0] && chModel[a] < coarseMax) begin
                chModel[a]++;
            end
            if (we[1] && fhModel[a] < fineMax) begin
                fhModel[a]++;
            end
        end
    endfunction

    // strictly greater wins, so a tie keeps the lower bin and empty gives 0
    function automatic binAddr_t peakSearch(input bit fine);
        int best;
        int bin;
        int cnt;
        best = 0;
        bin  = 0;
        for (int b = 1; b <= numBins; b++) begin
            cnt = fine ? fhModel[b] : chModel[b];
            if (cnt > best) begin
                best = cnt;
                bin  = b;
            end
        end
        return binAddr_t'(bin);
    endfunction

    function automatic void clearModel();
        for (int b = 1; b <= numBins; b++) begin
            chModel[b] = 0;
            fhModel[b] = 0;
        end
    endfunction

    task automatic sendHit(input logic [1:0] we, input binAddr_t a);
        @(negedge clk);
        wrEn = we;
        addr = a;
        modelHit(we, a);
    endtask

    task automatic sendHits(input logic [1:0] we, input binAddr_t a, input int n);
        for (int i = 0; i < n; i++) begin
            sendHit(we, a);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            wrEn      = 2'b00;
            acqFinish = 1'b0;
        end
    endtask

    // expected peaks are frozen here, the scan clears the model
    task automatic finishAcq();
        expCh = peakSearch(1'b0);
        expFh = peakSearch(1'b1);
        clearModel();
        validCount = 0;
        @(negedge clk);
        wrEn      = 2'b00;
        acqFinish = 1'b1;
        @(negedge clk);
        acqFinish = 1'b0;
    endtask

    task automatic waitPeak();
        int cycles;
        cycles = 0;
        while (!peakValid && cycles < peakTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!peakValid) begin
            timeouts++;
            $display("timeout in test %s, peakValid never came", testName);
        end else begin
            // checks fire on the rising edge in between
            @(negedge clk);
        end
    endtask

    task automatic runScan();
        finishAcq();
        waitPeak();
    endtask

    task automatic pulseReset();
        @(negedge clk);
        wrEn       = 2'b00;
        resetPulse = 1'b1;
        repeat (2) @(negedge clk);
        resetPulse = 1'b0;
        clearModel();
    endtask

    initial begin
        int cycles;
        int r;
        wrEn       = 2'b00;
        addr       = '0;
        acqFinish  = 1'b0;
        resetPulse = 1'b0;
        errors     = 0;
        timeouts   = 0;
        validCount = 0;
        expCh      = '0;
        expFh      = '0;
        seed       = 32'h8dbe_1f64;
        testName   = "reset";
        clearModel();

        // power-on reset release
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (reset && cycles < 20);
        if (reset) begin
            timeouts++;
            $display("timeout, reset was never released");
        end
        // valid, coarse peak and fine peak all low
        assert (!peakValid && peakCh == '0 && peakFh == '0)
            else begin
                errors++;
                $display("error %s expected 0 0 0 actual %0d %0d %0d",
                         testName, peakValid, peakCh, peakFh);
            end

        // coarse peak on 3, fine peak on 6
        testName = "distinctPeaks";
        sendHits(2'b01, binAddr_t'(3), 5);
        sendHits(2'b01, binAddr_t'(1), 2);
        sendHits(2'b01, binAddr_t'(6), 1);
        sendHits(2'b10, binAddr_t'(6), 4);
        sendHits(2'b10, binAddr_t'(3), 2);
        runScan();

        // tie between 2 and 5, then empty runs
        testName = "tieLowBin";
        sendHits(2'b11, binAddr_t'(5), 3);
        sendHits(2'b11, binAddr_t'(2), 3);
        runScan();
        testName = "emptyAfterScan";
        runScan();
        testName = "freshRun";
        sendHits(2'b11, binAddr_t'(4), 2);
        runScan();

        // bin 0 and out-of-range addresses
        testName = "illegalAddr";
        sendHits(2'b11, binAddr_t'(0), 5);
        sendHits(2'b11, binAddr_t'(9), 4);
        sendHits(2'b11, binAddr_t'(15), 3);
        sendHits(2'b01, binAddr_t'(12), 6);
        sendHit(2'b11, binAddr_t'(8));
        runScan();

        // hits and a second acqFinish while the scan runs
        testName = "scanDrop";
        sendHits(2'b11, binAddr_t'(2), 3);
        finishAcq();
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            wrEn      = 2'b11;
            addr      = binAddr_t'(4);
            acqFinish = (i == 2);
        end
        idleCycles(1);
        waitPeak();
        idleCycles(numBins + 6);
        assert (validCount == 1)
            else begin
                errors++;
                $display("error %s expected %0d actual %0d", testName, 1, validCount);
            end
        testName = "scanDropEmpty";
        runScan();

        // coarse clips at 63 on both bins, fine keeps counting
        testName = "saturate";
        sendHits(2'b11, binAddr_t'(2), 70);
        sendHits(2'b11, binAddr_t'(7), 65);
        runScan();
        testName = "fineOnly";
        sendHits(2'b10, binAddr_t'(2), 70);
        sendHits(2'b10, binAddr_t'(7), 80);
        runScan();
        // a wrapping coarse counter would let bin 4 win here
        testName = "coarseClip";
        sendHits(2'b01, binAddr_t'(3), 70);
        sendHits(2'b01, binAddr_t'(4), 20);
        runScan();

        // random strobes and addresses, illegal ones included
        testName = "random";
        for (int run = 0; run < 4; run++) begin
            for (int i = 0; i < 30; i++) begin
                r = $random(seed);
                sendHit(r[1:0], binAddr_t'(r[7:4]));
            end
            runScan();
        end

        // counts before the reset pulse are lost
        testName = "midReset";
        sendHits(2'b11, binAddr_t'(1), 6);
        pulseReset();
        sendHits(2'b11, binAddr_t'(5), 2);
        sendHits(2'b01, binAddr_t'(3), 1);
        runScan();

        idleCycles(2);
        $display("errors %0d timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/histPkg.sv
hw/histBusIf.sv
hw/hitSequencer.sv
hw/histogramBank.sv
hw/peakDetector.sv
hw/histogramTop.sv
test/clockGen.sv
test/histogramTopTb.sv

// ==== Makefile ====
TOP = histogramTopTb
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f verilog.f -Mdir obj_dir -o simv
	./obj_dir/simv > $(LOG) 2>&1; cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
